/* include/scratchpad_cfg.svh */
//////////////////////////////////////////////////
// Scratchpad sizes
//////////////////////////////////////////////////

`ifndef SCRATCHPAD_CFG_SVH
`define SCRATCHPAD_CFG_SVH

// Word address width, 256 words deep
`define SP_ADDR_W 8

// Data word width
`define SP_DATA_W 32

// Byte lanes per word
`define SP_BYTES 4

// Bits per byte lane
`define SP_BYTE_W 8

`endif

/* source/scratchpad_pkg.sv */
//////////////////////////////////////////////////
// Scratchpad types
//////////////////////////////////////////////////
`default_nettype none
`include "scratchpad_cfg.svh"

package scratchpad_pkg;

   typedef logic [`SP_DATA_W-1:0] word_t;
   typedef logic [`SP_ADDR_W-1:0] waddr_t;
   typedef logic [`SP_BYTES-1:0]  strb_t;
   typedef logic [`SP_ADDR_W:0]   len_t;   // One bit more than an address, up to 256

   typedef struct packed {
      logic   sel;     // One-cycle request strobe
      logic   space;   // High for register space
      waddr_t addr;
      strb_t  wstrb;   // Zero means read only
      word_t  wdata;
   } host_req_t;

   typedef struct packed {
      logic   en;
      strb_t  we;
      waddr_t addr;
      word_t  din;
   } ram_req_t;

   typedef enum logic [2:0] {
      REG_CTRL   = 3'd0,
      REG_VALUE  = 3'd1,
      REG_BASE   = 3'd2,
      REG_LEN    = 3'd3,
      REG_STATUS = 3'd4
   } reg_off_e;

   // Bit 1 drop, bit 0 busy
   typedef struct packed {
      logic drop;
      logic busy;
   } status_t;

   typedef struct packed {
      word_t  value;
      waddr_t base;
      len_t   len;
   } fill_cfg_t;

   typedef enum logic {
      FILL_IDLE,
      FILL_RUN
   } fill_state_e;

endpackage

`default_nettype wire

/* source/sp_ram_be.sv */
//////////////////////////////////////////////////
// Byte-enable single-port RAM
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "scratchpad_cfg.svh"

module sp_ram_be
   import scratchpad_pkg::*;
(
   input  logic   clk,
   input  logic   en,
   input  strb_t  we,
   input  waddr_t addr,
   input  word_t  din,
   output word_t  dout
);

   localparam int DEPTH = 1 << `SP_ADDR_W;

   // Storage array
   word_t mem [DEPTH];

   // Read-first port
   // The registered output always carries the word as it was before this
   // cycle's write, so a write access still returns the old contents
   always_ff @(posedge clk) begin
      if (en) begin
         for (int i = 0; i < `SP_BYTES; i++) begin
            if (we[i]) begin
               mem[addr][i*`SP_BYTE_W +: `SP_BYTE_W] <= din[i*`SP_BYTE_W +: `SP_BYTE_W];
            end
         end
         dout <= mem[addr];   // Old word
      end
   end

endmodule

`default_nettype wire

/* source/fill_engine.sv */
//////////////////////////////////////////////////
// Fill engine
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "scratchpad_cfg.svh"

module fill_engine
   import scratchpad_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  logic      start,
   input  fill_cfg_t cfg,
   output ram_req_t  fill_req,
   output logic      busy
);

   fill_state_e state_q;
   word_t       value_q;   // Fill word held for the whole run
   waddr_t      addr_q;    // Next address to write
   len_t        cnt_q;     // Words still to write

   // Control path
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= FILL_IDLE;
         addr_q  <= '0;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            FILL_IDLE: begin
               // A zero length gives no busy cycle at all
               if (start && cfg.len != '0) begin
                  state_q <= FILL_RUN;
                  addr_q  <= cfg.base;
                  cnt_q   <= cfg.len;
               end
            end
            FILL_RUN: begin
               addr_q <= addr_q + 1'b1;   // Wraps modulo depth
               cnt_q  <= cnt_q - 1'b1;
               if (cnt_q == len_t'(1)) begin
                  state_q <= FILL_IDLE;   // Last word goes out this cycle
               end
            end
            default: begin
               state_q <= FILL_IDLE;
            end
         endcase
      end
   end

   // Fill word capture
   always_ff @(posedge clk) begin
      if (state_q == FILL_IDLE && start) begin
         value_q <= cfg.value;
      end
   end

   assign busy = (state_q == FILL_RUN);

   // One full-word write per running cycle
   always_comb begin
      fill_req.en   = busy;
      fill_req.we   = busy ? strb_t'({`SP_BYTES{1'b1}}) : strb_t'(0);
      fill_req.addr = addr_q;
      fill_req.din  = value_q;
   end

endmodule

`default_nettype wire

/* source/fill_regs.sv */
//////////////////////////////////////////////////
// Fill control registers
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "scratchpad_cfg.svh"

module fill_regs
   import scratchpad_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  logic      reg_wr,
   input  logic      reg_rd,
   input  reg_off_e  reg_off,
   input  word_t     reg_wdata,
   input  logic      drop_set,
   input  logic      busy,
   output word_t     reg_rdata,
   output fill_cfg_t cfg,
   output logic      start
);

   word_t   value_q;
   waddr_t  base_q;
   len_t    len_q;
   logic    drop_q;
   logic    start_q;
   status_t status;

   logic    ctrl_wr;
   logic    status_wr;

   assign ctrl_wr   = reg_wr && (reg_off == REG_CTRL);
   assign status_wr = reg_wr && (reg_off == REG_STATUS);

   // Settings, start pulse and drop flag
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         value_q <= '0;
         base_q  <= '0;
         len_q   <= '0;
         drop_q  <= 1'b0;
         start_q <= 1'b0;
      end else begin
         if (reg_wr && reg_off == REG_VALUE) begin
            value_q <= reg_wdata;
         end
         if (reg_wr && reg_off == REG_BASE) begin
            base_q <= reg_wdata[`SP_ADDR_W-1:0];
         end
         if (reg_wr && reg_off == REG_LEN) begin
            len_q <= reg_wdata[`SP_ADDR_W:0];
         end

         // Ignored while a fill runs or is about to begin
         start_q <= ctrl_wr && reg_wdata[0] && !busy && !start_q;

         // Write-one-to-clear, a new drop in the same cycle wins
         if (status_wr && reg_wdata[1]) begin
            drop_q <= 1'b0;
         end
         if (drop_set) begin
            drop_q <= 1'b1;
         end
      end
   end

   assign status = '{drop: drop_q, busy: busy};

   // Read data is sampled in the request cycle
   always_ff @(posedge clk) begin
      if (reg_rd) begin
         case (reg_off)
            REG_VALUE:  reg_rdata <= value_q;
            REG_BASE:   reg_rdata <= word_t'(base_q);
            REG_LEN:    reg_rdata <= word_t'(len_q);
            REG_STATUS: reg_rdata <= word_t'(status);
            default:    reg_rdata <= '0;   // CTRL and unmapped
         endcase
      end
   end

   assign cfg   = '{value: value_q, base: base_q, len: len_q};
   assign start = start_q;

endmodule

`default_nettype wire

/* source/mem_port_mux.sv */
//////////////////////////////////////////////////
// Host port decode and return path
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "scratchpad_cfg.svh"

module mem_port_mux
   import scratchpad_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  host_req_t host,
   input  ram_req_t  fill_req,
   input  logic      busy,
   output ram_req_t  ram_req,
   input  word_t     ram_dout,
   output logic      reg_wr,
   output logic      reg_rd,
   output logic      drop_set,
   output reg_off_e  reg_off,
   output word_t     reg_wdata,
   input  word_t     reg_rdata,
   output word_t     rdata,
   output logic      rvalid
);

   logic host_mem;
   logic host_reg;
   logic mem_ok;

   logic rvalid_q;
   logic from_reg_q;   // Which space the pending word comes from

   assign host_mem = host.sel && !host.space;
   assign host_reg = host.sel && host.space;

   // The engine owns the RAM while busy
   assign mem_ok   = host_mem && !busy;
   assign drop_set = host_mem && busy;

   always_comb begin
      if (busy) begin
         ram_req = fill_req;
      end else begin
         ram_req.en   = mem_ok;
         ram_req.we   = mem_ok ? host.wstrb : strb_t'(0);
         ram_req.addr = host.addr;
         ram_req.din  = host.wdata;
      end
   end

   // Register side
   // Any nonzero strobe writes the whole register
   assign reg_wr    = host_reg && (host.wstrb != '0);
   assign reg_rd    = host_reg;
   assign reg_off   = reg_off_e'(host.addr[2:0]);
   assign reg_wdata = host.wdata;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rvalid_q   <= 1'b0;
         from_reg_q <= 1'b0;
      end else begin
         rvalid_q   <= mem_ok || host_reg;   // Dropped requests give no answer
         from_reg_q <= host_reg;
      end
   end

   assign rdata  = from_reg_q ? reg_rdata : ram_dout;
   assign rvalid = rvalid_q;

endmodule

`default_nettype wire

/* source/scratchpad_top.sv */
//////////////////////////////////////////////////
// Scratchpad with fill engine
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "scratchpad_cfg.svh"

module scratchpad_top
   import scratchpad_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  host_req_t host,
   output word_t     rdata,
   output logic      rvalid,
   output logic      busy
);

   ram_req_t  ram_req;
   ram_req_t  fill_req;
   word_t     ram_dout;

   logic      reg_wr;
   logic      reg_rd;
   logic      drop_set;
   reg_off_e  reg_off;
   word_t     reg_wdata;
   word_t     reg_rdata;

   fill_cfg_t fill_cfg;
   logic      start;

   // Host decode, arbitration and read return
   mem_port_mux u_mux (
      .clk       (clk),
      .arst_n    (arst_n),
      .host      (host),
      .fill_req  (fill_req),
      .busy      (busy),
      .ram_req   (ram_req),
      .ram_dout  (ram_dout),
      .reg_wr    (reg_wr),
      .reg_rd    (reg_rd),
      .drop_set  (drop_set),
      .reg_off   (reg_off),
      .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata),
      .rdata     (rdata),
      .rvalid    (rvalid)
   );

   sp_ram_be u_ram (
      .clk  (clk),
      .en   (ram_req.en),
      .we   (ram_req.we),
      .addr (ram_req.addr),
      .din  (ram_req.din),
      .dout (ram_dout)
   );

   // Settings and start for the engine next to it
   fill_regs u_regs (
      .clk       (clk),
      .arst_n    (arst_n),
      .reg_wr    (reg_wr),
      .reg_rd    (reg_rd),
      .reg_off   (reg_off),
      .reg_wdata (reg_wdata),
      .drop_set  (drop_set),
      .busy      (busy),
      .reg_rdata (reg_rdata),
      .cfg       (fill_cfg),
      .start     (start)
   );

   fill_engine u_fill (
      .clk      (clk),
      .arst_n   (arst_n),
      .start    (start),
      .cfg      (fill_cfg),
      .fill_req (fill_req),
      .busy     (busy)
   );

endmodule

`default_nettype wire

/* tb/scratchpad_tb.sv */
//////////////////////////////////////////////////
// Scratchpad testbench
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "scratchpad_cfg.svh"

module scratchpad_tb
   import scratchpad_pkg::*;
();

   localparam int DEPTH    = 1 << `SP_ADDR_W;
   localparam int POLL_MAX = 400;

   logic      clk;
   logic      arst_n;
   host_req_t host;
   word_t     rdata;
   logic      rvalid;
   logic      busy;

   integer    seed;
   int        cyc = 0;      // Rising edges so far
   int        fill_first;   // Cycle window in which the engine should be busy
   int        fill_last;
   int        word_errs;
   int        status_errs;
   int        other_errs;

   // Reference model
   word_t     model_mem [DEPTH];
   strb_t     model_vld [DEPTH];   // Bytes written since reset
   word_t     model_value;
   waddr_t    model_base;
   len_t      model_len;
   logic      model_drop;

   scratchpad_top uut (.*);

   initial clk = 1'b0;
   always #50 clk = ~clk;
   always @(posedge clk) cyc <= cyc + 1;

   function automatic logic model_busy();
      return (cyc >= fill_first) && (cyc <= fill_last);
   endfunction

   function automatic word_t lane_mask(input strb_t s);
      word_t m;
      for (int i = 0; i < `SP_BYTES; i++) begin
         m[i*`SP_BYTE_W +: `SP_BYTE_W] = {`SP_BYTE_W{s[i]}};
      end
      return m;
   endfunction

   // Expected register read, busy as seen in the request cycle
   function automatic word_t reg_expect(input logic [2:0] off);
      case (off)
         REG_VALUE:  return model_value;
         REG_BASE:   return word_t'(model_base);
         REG_LEN:    return word_t'(model_len);
         REG_STATUS: return word_t'({model_drop, model_busy()});
         default:    return '0;
      endcase
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp,
                             input word_t mask);
      if ((got & mask) !== (exp & mask)) begin
         word_errs++;
         $display("[ERROR] %0t ns %s got %08h expected %08h mask %08h",
                  $time, name, got, exp, mask);
      end
   endtask

   task automatic check_status(input status_t got, input status_t exp);
      if (got !== exp) begin
         status_errs++;
         $display("[ERROR] %0t ns status got %02b expected %02b", $time, got, exp);
      end
   endtask

   task automatic check_busy(input logic got, input logic exp);
      if (got !== exp) begin
         status_errs++;
         $display("[ERROR] %0t ns busy got %b expected %b", $time, got, exp);
      end
   endtask

   // One request on a falling edge, answer taken on the next one
   task automatic access(input logic space, input waddr_t addr, input strb_t wstrb,
                         input word_t wdata, output word_t got);
      logic  drop;
      word_t exp;
      word_t mask;
      check_busy(busy, model_busy());
      drop = !space && model_busy();   // Engine owns the RAM
      exp  = space ? reg_expect(addr[2:0]) : model_mem[addr];
      mask = space ? ~word_t'(0) : lane_mask(model_vld[addr]);
      host = '{sel: 1'b1, space: space, addr: addr, wstrb: wstrb, wdata: wdata};
      @(negedge clk);
      host.sel = 1'b0;
      got      = rdata;
      if (drop) begin
         model_drop = 1'b1;
      end
      if (rvalid !== !drop) begin
         other_errs++;
         $display("Request at %0t ns %s", $time,
                  drop ? "was answered during a fill" : "got no read data back");
      end else if (space && addr[2:0] == REG_STATUS) begin
         check_status(status_t'(got[1:0]), status_t'(exp[1:0]));
         check_word("rdata", got, exp, ~word_t'(3));   // Upper status bits read 0
      end else if (!drop) begin
         check_word("rdata", got, exp, mask);
      end
      if (!space && !drop) begin
         model_mem[addr] = (model_mem[addr] & ~lane_mask(wstrb)) | (wdata & lane_mask(wstrb));
         model_vld[addr] = model_vld[addr] | wstrb;
      end else if (space && wstrb != '0) begin
         case (addr[2:0])
            REG_VALUE:  model_value = wdata;
            REG_BASE:   model_base  = wdata[`SP_ADDR_W-1:0];
            REG_LEN:    model_len   = wdata[`SP_ADDR_W:0];
            REG_STATUS: model_drop  = model_drop && !wdata[1];   // Write one to clear
            default: ;
         endcase
      end
   endtask

   // Program, start and finish one fill, then read back every word
   task automatic run_fill(input word_t value, input waddr_t base, input len_t len,
                           input logic poke);
      int     polls;
      waddr_t a;
      word_t  got;
      access(1'b1, waddr_t'(REG_VALUE), 4'hF, value, got);
      access(1'b1, waddr_t'(REG_BASE), 4'hF, word_t'(base), got);
      access(1'b1, waddr_t'(REG_LEN), 4'hF, word_t'(len), got);
      fill_first = cyc + 2;   // Start pulse first, busy from the edge after
      fill_last  = cyc + 1 + int'(len);
      a = base;
      for (int k = 0; k < int'(len); k++) begin
         model_mem[a] = value;
         model_vld[a] = '1;
         a = a + 8'd1;   // Wraps
      end
      access(1'b1, waddr_t'(REG_CTRL), 4'hF, 32'h1, got);
      @(negedge clk);   // Start pulse cycle, busy not yet visible
      if (poke) begin
         access(1'b0, base - 8'd1, 4'hF, word_t'($random(seed)), got);   // Dropped
         access(1'b1, waddr_t'(REG_VALUE), '0, '0, got);
         access(1'b1, waddr_t'(REG_STATUS), 4'hF, 32'h2, got);
      end
      polls = 0;
      got   = 32'h1;
      while (got[0] !== 1'b0 && polls < POLL_MAX) begin
         access(1'b1, waddr_t'(REG_STATUS), '0, '0, got);
         polls++;
      end
      if (got[0] !== 1'b0) begin
         other_errs++;
         $display("Fill engine still busy after %0d status polls", POLL_MAX);
      end
      for (int i = 0; i < DEPTH; i++) begin
         access(1'b0, waddr_t'(i), '0, '0, got);
      end
   endtask

   initial begin
      word_t      got;
      word_t      wdata;
      logic [2:0] off;
      seed        = 57911;
      fill_first  = 1;
      fill_last   = 0;
      word_errs   = 0;
      status_errs = 0;
      other_errs  = 0;
      model_value = '0;
      model_base  = '0;
      model_len   = '0;
      model_drop  = 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
         model_mem[i] = '0;
         model_vld[i] = '0;
      end
      host   = '0;
      arst_n = 1'b0;
      repeat (8) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      // Reset values, then random register traffic
      for (int i = 0; i < 8; i++) begin
         access(1'b1, waddr_t'(i), '0, '0, got);
      end
      for (int i = 0; i < 40; i++) begin
         off   = 3'($random(seed));
         wdata = word_t'($random(seed));
         if (off == 3'd0) wdata[0] = 1'b0;   // No fill start here
         access(1'b1, {5'($random(seed)), off}, strb_t'($random(seed)), wdata, got);
      end

      // Read-first on a fixed word
      access(1'b0, 8'h10, 4'hF, 32'hA5A5_A5A5, got);
      access(1'b0, 8'h10, 4'b0101, 32'h1122_3344, got);
      check_word("rdata", got, 32'hA5A5_A5A5, ~word_t'(0));
      access(1'b0, 8'h10, '0, '0, got);
      check_word("rdata", got, 32'hA522_A544, ~word_t'(0));

      // Random memory traffic, a zero strobe is a read
      for (int i = 0; i < 400; i++) begin
         access(1'b0, waddr_t'($random(seed)), strb_t'($random(seed)),
                word_t'($random(seed)), got);
      end

      for (int i = 0; i < 3; i++) begin
         run_fill(word_t'($random(seed)), waddr_t'($random(seed)),
                  len_t'({$random(seed)} % 257), 1'b0);
      end
      run_fill(word_t'($random(seed)), waddr_t'($random(seed)), len_t'(0), 1'b0);
      run_fill(word_t'($random(seed)), waddr_t'($random(seed)), len_t'(256), 1'b0);
      run_fill(word_t'($random(seed)), waddr_t'($random(seed)), len_t'(120), 1'b1);

      $display("Errors: %0d word, %0d status, %0d other", word_errs, status_errs, other_errs);
      if (word_errs + status_errs + other_errs == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* scratchpad.f */
+incdir+include
source/scratchpad_pkg.sv
source/sp_ram_be.sv
source/fill_engine.sv
source/fill_regs.sv
source/mem_port_mux.sv
source/scratchpad_top.sv
tb/scratchpad_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the scratchpad testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
   --top-module scratchpad_tb \
   -f scratchpad.f \
   -o scratchpad_sim

./obj_dir/scratchpad_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed"
exit 1
